//--- logic/csr_pkg.sv
package csr_pkg;

    localparam int CSR_ADDR_W = 14;
    localparam int CSR_DATA_W = 32;
    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;
    localparam int HW_INT_W   = 8;
    localparam int INT_MASK_W = 13;
    localparam int TIMER_W    = 64;

    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [CSR_DATA_W-1:0] csr_data_t;

    // kept register addresses
    localparam csr_addr_t CSR_CRMD   = 14'h0;
    localparam csr_addr_t CSR_PRMD   = 14'h1;
    localparam csr_addr_t CSR_ECFG   = 14'h4;
    localparam csr_addr_t CSR_ESTAT  = 14'h5;
    localparam csr_addr_t CSR_ERA    = 14'h6;
    localparam csr_addr_t CSR_BADV   = 14'h7;
    localparam csr_addr_t CSR_EENTRY = 14'hc;
    localparam csr_addr_t CSR_SAVE0  = 14'h30;
    localparam csr_addr_t CSR_SAVE1  = 14'h31;
    localparam csr_addr_t CSR_SAVE2  = 14'h32;
    localparam csr_addr_t CSR_SAVE3  = 14'h33;
    localparam csr_addr_t CSR_TID    = 14'h40;
    localparam csr_addr_t CSR_TCFG   = 14'h41;
    localparam csr_addr_t CSR_TVAL   = 14'h42;
    localparam csr_addr_t CSR_TICLR  = 14'h44;

    // field low bits
    localparam int CRMD_PLV  = 0;
    localparam int CRMD_IE   = 2;
    localparam int CRMD_DA   = 3;
    localparam int CRMD_PG   = 4;
    localparam int CRMD_DATF = 5;
    localparam int CRMD_DATM = 7;
    localparam csr_data_t CRMD_RESET = 32'h0000_0008;

    localparam int PRMD_PPLV = 0;
    localparam int PRMD_PIE  = 2;

    localparam csr_data_t ECFG_MASK = 32'h0000_1bff;

    localparam int ESTAT_SWI      = 0;
    localparam int ESTAT_HWI      = 2;
    localparam int ESTAT_TI       = 11;
    localparam int ESTAT_ECODE    = 16;
    localparam int ESTAT_ESUBCODE = 22;

    localparam csr_data_t EENTRY_MASK = 32'hffff_ffc0;

    localparam int TCFG_EN       = 0;
    localparam int TCFG_PERIODIC = 1;
    localparam int TCFG_INITVAL  = 2;
    localparam csr_data_t TCFG_MASK = 32'hffff_ffff;

    localparam int TICLR_CLR = 0;

    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        csr_data_t data;
    } csr_write_t;

    typedef struct packed {
        logic                  flush;
        logic                  ertn;
        logic [ECODE_W-1:0]    ecode;
        logic [ESUBCODE_W-1:0] esubcode;
        csr_data_t             era;
        // bad address strobe, independent of flush
        logic                  badv_en;
        csr_data_t             badv;
    } csr_excp_t;

    typedef struct packed {
        logic       crmd;
        logic       prmd;
        logic       ecfg;
        logic       estat;
        logic       era;
        logic       badv;
        logic       eentry;
        logic [3:0] save;
        logic       tid;
        logic       tcfg;
        logic       tval;
        logic       ticlr;
    } csr_wen_t;

    typedef struct packed {
        logic [22:0] rsvd;
        logic [1:0]  datm;
        logic [1:0]  datf;
        logic        pg;
        logic        da;
        logic        ie;
        logic [1:0]  plv;
    } crmd_t;

endpackage

//--- logic/csr_write_decode.sv
module csr_write_decode
    import csr_pkg::*;
(
    input  csr_write_t wr,
    output csr_wen_t   wen
);

    // one strobe per kept register, nothing for unknown addresses
    always_comb begin
        wen = '0;
        if (wr.en) begin
            case (wr.addr)
                CSR_CRMD:   wen.crmd    = 1'b1;
                CSR_PRMD:   wen.prmd    = 1'b1;
                CSR_ECFG:   wen.ecfg    = 1'b1;
                CSR_ESTAT:  wen.estat   = 1'b1;
                CSR_ERA:    wen.era     = 1'b1;
                CSR_BADV:   wen.badv    = 1'b1;
                CSR_EENTRY: wen.eentry  = 1'b1;
                CSR_SAVE0:  wen.save[0] = 1'b1;
                CSR_SAVE1:  wen.save[1] = 1'b1;
                CSR_SAVE2:  wen.save[2] = 1'b1;
                CSR_SAVE3:  wen.save[3] = 1'b1;
                CSR_TID:    wen.tid     = 1'b1;
                CSR_TCFG:   wen.tcfg    = 1'b1;
                CSR_TVAL:   wen.tval    = 1'b1;
                CSR_TICLR:  wen.ticlr   = 1'b1;
                default:    wen         = '0;
            endcase
        end
    end

endmodule

//--- logic/csr_exception_regs.sv
module csr_exception_regs
    import csr_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  csr_wen_t            wen,
    input  csr_data_t           wdata,
    input  csr_excp_t           excp,
    input  logic [HW_INT_W-1:0] interrupt,
    input  logic                ti_flag,
    output csr_data_t           crmd,
    output csr_data_t           prmd,
    output csr_data_t           ecfg,
    output csr_data_t           estat,
    output csr_data_t           era,
    output csr_data_t           badv,
    output csr_data_t           eentry,
    output logic                has_int,
    output logic [1:0]          plv
);

    crmd_t                 crmd_q;
    logic [1:0]            pplv;
    logic                  pie;
    logic [INT_MASK_W-1:0] ecfg_q;
    logic [1:0]            swi;
    logic [HW_INT_W-1:0]   hwi;
    logic [ECODE_W-1:0]    ecode;
    logic [ESUBCODE_W-1:0] esubcode;

    // entry beats return beats software write
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_q <= crmd_t'(CRMD_RESET);
        end else if (excp.flush) begin
            crmd_q.plv <= 2'b0;
            crmd_q.ie  <= 1'b0;
        end else if (excp.ertn) begin
            crmd_q.plv <= pplv;
            crmd_q.ie  <= pie;
        end else if (wen.crmd) begin
            crmd_q.plv  <= wdata[CRMD_PLV +: 2];
            crmd_q.ie   <= wdata[CRMD_IE];
            crmd_q.da   <= wdata[CRMD_DA];
            crmd_q.pg   <= wdata[CRMD_PG];
            crmd_q.datf <= wdata[CRMD_DATF +: 2];
            crmd_q.datm <= wdata[CRMD_DATM +: 2];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pplv <= 2'b0;
            pie  <= 1'b0;
        end else if (excp.flush) begin
            pplv <= crmd_q.plv;
            pie  <= crmd_q.ie;
        end else if (wen.prmd) begin
            pplv <= wdata[PRMD_PPLV +: 2];
            pie  <= wdata[PRMD_PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_q   <= '0;
            swi      <= 2'b0;
            hwi      <= '0;
            ecode    <= '0;
            esubcode <= '0;
        end else begin
            if (wen.ecfg) begin
                ecfg_q <= wdata[INT_MASK_W-1:0] & ECFG_MASK[INT_MASK_W-1:0];
            end
            if (wen.estat) begin
                swi <= wdata[ESTAT_SWI +: 2];
            end
            // hardware lines land one cycle late
            hwi <= interrupt;
            if (excp.flush) begin
                ecode    <= excp.ecode;
                esubcode <= excp.esubcode;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            era    <= '0;
            badv   <= '0;
            eentry <= '0;
        end else begin
            if (excp.flush) begin
                era <= excp.era;
            end else if (wen.era) begin
                era <= wdata;
            end
            // software write wins over the bad address strobe
            if (wen.badv) begin
                badv <= wdata;
            end else if (excp.badv_en) begin
                badv <= excp.badv;
            end
            if (wen.eentry) begin
                eentry <= wdata & EENTRY_MASK;
            end
        end
    end

    assign crmd = crmd_q;
    assign prmd = {{(CSR_DATA_W-3){1'b0}}, pie, pplv};
    assign ecfg = {{(CSR_DATA_W-INT_MASK_W){1'b0}}, ecfg_q};

    always_comb begin
        estat = '0;
        estat[ESTAT_SWI +: 2]               = swi;
        estat[ESTAT_HWI +: HW_INT_W]        = hwi;
        estat[ESTAT_TI]                     = ti_flag;
        estat[ESTAT_ECODE +: ECODE_W]       = ecode;
        estat[ESTAT_ESUBCODE +: ESUBCODE_W] = esubcode;
    end

    assign has_int = (|(ecfg_q & estat[INT_MASK_W-1:0])) & crmd_q.ie;

    // privilege level seen by fetch this cycle
    always_comb begin
        if (excp.flush) begin
            plv = 2'b0;
        end else if (excp.ertn) begin
            plv = pplv;
        end else if (wen.crmd) begin
            plv = wdata[CRMD_PLV +: 2];
        end else begin
            plv = crmd_q.plv;
        end
    end

endmodule

//--- logic/csr_timer.sv
module csr_timer
    import csr_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  csr_wen_t           wen,
    input  csr_data_t          wdata,
    output csr_data_t          tid,
    output csr_data_t          tcfg,
    output csr_data_t          tval,
    output logic               ti_flag,
    output logic [TIMER_W-1:0] timer
);

    logic timer_en;
    logic expire;

    assign expire = timer_en && (tval == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            tid  <= '0;
            tcfg <= '0;
        end else begin
            if (wen.tid) begin
                tid <= wdata;
            end
            if (wen.tcfg) begin
                tcfg <= wdata & TCFG_MASK;
            end
        end
    end

    // down-counter, reload on expiry
    always_ff @(posedge clk) begin
        if (reset) begin
            tval     <= '0;
            timer_en <= 1'b0;
        end else if (wen.tcfg) begin
            tval     <= {wdata[CSR_DATA_W-1:TCFG_INITVAL], 2'b00};
            timer_en <= wdata[TCFG_EN];
        end else begin
            if (wen.tval) begin
                tval <= wdata;
            end else if (expire) begin
                tval <= tcfg[TCFG_PERIODIC] ? {tcfg[CSR_DATA_W-1:TCFG_INITVAL], 2'b00}
                                            : '1;
            end else if (timer_en) begin
                tval <= tval - 1'b1;
            end
            if (expire) begin
                timer_en <= tcfg[TCFG_PERIODIC];
            end
        end
    end

    // clear has priority, a tcfg write holds off the set
    always_ff @(posedge clk) begin
        if (reset) begin
            ti_flag <= 1'b0;
        end else if (wen.ticlr && wdata[TICLR_CLR]) begin
            ti_flag <= 1'b0;
        end else if (expire && !wen.tcfg) begin
            ti_flag <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            timer <= '0;
        end else begin
            timer <= timer + 1'b1;
        end
    end

endmodule

//--- logic/csr_save_bank.sv
module csr_save_bank
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  csr_wen_t  wen,
    input  csr_data_t wdata,
    output csr_data_t save [4]
);

    // scratch registers for the exception handler
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                save[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (wen.save[i]) begin
                    save[i] <= wdata;
                end
            end
        end
    end

endmodule

//--- logic/csr_read_mux.sv
module csr_read_mux
    import csr_pkg::*;
(
    input  csr_addr_t  raddr,
    input  csr_write_t wr,
    input  csr_data_t  crmd,
    input  csr_data_t  prmd,
    input  csr_data_t  ecfg,
    input  csr_data_t  estat,
    input  csr_data_t  era,
    input  csr_data_t  badv,
    input  csr_data_t  eentry,
    input  csr_data_t  tid,
    input  csr_data_t  tcfg,
    input  csr_data_t  tval,
    input  csr_data_t  save [4],
    output csr_data_t  rdata
);

    always_comb begin
        if (wr.en && (wr.addr == raddr)) begin
            // same-cycle write bypass
            rdata = wr.data;
        end else begin
            case (raddr)
                CSR_CRMD:   rdata = crmd;
                CSR_PRMD:   rdata = prmd;
                CSR_ECFG:   rdata = ecfg;
                CSR_ESTAT:  rdata = estat;
                CSR_ERA:    rdata = era;
                CSR_BADV:   rdata = badv;
                CSR_EENTRY: rdata = eentry;
                CSR_SAVE0:  rdata = save[0];
                CSR_SAVE1:  rdata = save[1];
                CSR_SAVE2:  rdata = save[2];
                CSR_SAVE3:  rdata = save[3];
                CSR_TID:    rdata = tid;
                CSR_TCFG:   rdata = tcfg;
                CSR_TVAL:   rdata = tval;
                // ticlr and unknown addresses read zero
                default:    rdata = '0;
            endcase
        end
    end

endmodule

//--- logic/csr_top.sv
module csr_top
    import csr_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  csr_addr_t           csr_raddr,
    output csr_data_t           csr_rdata,
    input  csr_write_t          wr,
    input  csr_excp_t           excp,
    input  logic [HW_INT_W-1:0] interrupt,
    output logic                has_int,
    output logic [1:0]          plv,
    output csr_data_t           eentry,
    output csr_data_t           era,
    output csr_data_t           tid,
    output logic [TIMER_W-1:0]  timer
);

    csr_wen_t  wen;
    csr_data_t crmd;
    csr_data_t prmd;
    csr_data_t ecfg;
    csr_data_t estat;
    csr_data_t badv;
    csr_data_t tcfg;
    csr_data_t tval;
    csr_data_t save [4];
    logic      ti_flag;

    csr_write_decode u_decode (
        .wr  (wr),
        .wen (wen)
    );

    csr_exception_regs u_excp (
        .clk       (clk),
        .reset     (reset),
        .wen       (wen),
        .wdata     (wr.data),
        .excp      (excp),
        .interrupt (interrupt),
        .ti_flag   (ti_flag),
        .crmd      (crmd),
        .prmd      (prmd),
        .ecfg      (ecfg),
        .estat     (estat),
        .era       (era),
        .badv      (badv),
        .eentry    (eentry),
        .has_int   (has_int),
        .plv       (plv)
    );

    csr_timer u_timer (
        .clk     (clk),
        .reset   (reset),
        .wen     (wen),
        .wdata   (wr.data),
        .tid     (tid),
        .tcfg    (tcfg),
        .tval    (tval),
        .ti_flag (ti_flag),
        .timer   (timer)
    );

    csr_save_bank u_save (
        .clk   (clk),
        .reset (reset),
        .wen   (wen),
        .wdata (wr.data),
        .save  (save)
    );

    csr_read_mux u_rmux (
        .raddr  (csr_raddr),
        .wr     (wr),
        .crmd   (crmd),
        .prmd   (prmd),
        .ecfg   (ecfg),
        .estat  (estat),
        .era    (era),
        .badv   (badv),
        .eentry (eentry),
        .tid    (tid),
        .tcfg   (tcfg),
        .tval   (tval),
        .save   (save),
        .rdata  (csr_rdata)
    );

endmodule

//--- verification/csr_tests.svh
`ifndef CSR_TESTS_SVH
`define CSR_TESTS_SVH

task automatic reset_values();
    csr_addr_t zero_regs [13] = '{CSR_PRMD, CSR_ECFG, CSR_ESTAT, CSR_ERA, CSR_BADV,
        CSR_EENTRY, CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TID, CSR_TCFG, CSR_TVAL};
    check(has_int, 1'b0, "has_int after reset");
    check(plv, 2'd0, "plv after reset");
    expect_reg(CSR_CRMD, 32'h0000_0008, "crmd after reset");
    foreach (zero_regs[i]) begin
        expect_reg(zero_regs[i], 32'h0, $sformatf("csr %h after reset", zero_regs[i]));
    end
endtask

task automatic write_readback();
    csr_addr_t addrs [8] = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3,
        CSR_ERA, CSR_TID, CSR_ECFG, CSR_EENTRY};
    csr_data_t masks [8] = '{32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff,
        32'hffff_ffff, 32'hffff_ffff, 32'h0000_1bff, 32'hffff_ffc0};
    csr_data_t value;
    foreach (addrs[i]) begin
        value = $random(seed);
        write_reg(addrs[i], value);
        expect_reg(addrs[i], value & masks[i], $sformatf("readback of csr %h", addrs[i]));
        // fetch and pipeline ports follow the registers
        if (addrs[i] == CSR_EENTRY) begin
            check(eentry, value & masks[i], "eentry port after write");
        end
        if (addrs[i] == CSR_TID) begin
            check(tid, value, "tid port after write");
        end
    end
endtask

task automatic exception_round_trip();
    logic [ECODE_W-1:0]    ecode;
    logic [ESUBCODE_W-1:0] esubcode;
    csr_data_t             ret_pc;
    ecode    = ECODE_W'($random(seed));
    esubcode = ESUBCODE_W'($random(seed));
    ret_pc   = $random(seed);
    // plv 3 and ie set, da stays on
    write_reg(CSR_CRMD, 32'h0000_000f);
    excp.flush    = 1'b1;
    excp.ecode    = ecode;
    excp.esubcode = esubcode;
    excp.era      = ret_pc;
    #1;
    check(plv, 2'd0, "plv during flush");
    next_edge();
    clear_strobes();
    expect_reg(CSR_CRMD, 32'h0000_0008, "crmd after entry");
    expect_reg(CSR_PRMD, 32'h0000_0007, "prmd after entry");
    expect_reg(CSR_ERA, ret_pc, "era after entry");
    check(era, ret_pc, "era port after entry");
    expect_reg(CSR_ESTAT, {1'b0, esubcode, ecode, 16'h0}, "estat codes after entry");
    excp.ertn = 1'b1;
    #1;
    check(plv, 2'd3, "plv during ertn");
    next_edge();
    clear_strobes();
    expect_reg(CSR_CRMD, 32'h0000_000f, "crmd after return");
endtask

task automatic interrupt_lines();
    write_reg(CSR_CRMD, 32'h0000_000c);
    // line 2 lands on estat bit 4
    write_reg(CSR_ECFG, 32'h0000_0010);
    interrupt = 8'h04;
    wait_for_int(INT_TIMEOUT, "hardware interrupt");
    expect_bit(CSR_ESTAT, 4, 1'b1, "estat bit of line 2");
    write_reg(CSR_ECFG, 32'h0);
    check(has_int, 1'b0, "has_int with line 2 masked");
    interrupt = 8'h00;
    write_reg(CSR_ECFG, 32'h0000_0001);
    write_reg(CSR_ESTAT, 32'h0000_0001);
    check(has_int, 1'b1, "has_int from software bit 0");
    write_reg(CSR_ESTAT, 32'h0);
    write_reg(CSR_ECFG, 32'h0);
    check(has_int, 1'b0, "has_int after software bit cleared");
endtask

task automatic oneshot_timer();
    write_reg(CSR_CRMD, 32'h0000_000c);
    write_reg(CSR_ECFG, 32'h0000_0800);
    // initval 4, enabled, not periodic
    write_reg(CSR_TCFG, (32'd4 << TCFG_INITVAL) | 32'h1);
    wait_for_int(TIMER_TIMEOUT, "timer interrupt");
    expect_bit(CSR_ESTAT, ESTAT_TI, 1'b1, "estat timer bit");
    repeat (3) begin
        expect_reg(CSR_TVAL, 32'hffff_ffff, "tval after one-shot expiry");
    end
    write_reg(CSR_TICLR, 32'h0000_0001);
    check(has_int, 1'b0, "has_int after ticlr");
    expect_bit(CSR_ESTAT, ESTAT_TI, 1'b0, "estat timer bit after ticlr");
    check(timer, cycle_count, "free-running counter against elapsed cycles");
    write_reg(CSR_ECFG, 32'h0);
endtask

task automatic badv_priority();
    csr_data_t fault_addr;
    csr_data_t sw_value;
    fault_addr   = $random(seed);
    sw_value     = $random(seed);
    excp.badv_en = 1'b1;
    excp.badv    = fault_addr;
    next_edge();
    clear_strobes();
    expect_reg(CSR_BADV, fault_addr, "badv from strobe");
    // strobe and software write in one cycle
    excp.badv_en = 1'b1;
    excp.badv    = ~sw_value;
    write_reg(CSR_BADV, sw_value);
    expect_reg(CSR_BADV, sw_value, "software write over badv strobe");
endtask

`endif

//--- verification/csr_tb.sv
module csr_tb
    import csr_pkg::*;
();

    localparam int INT_TIMEOUT   = 20;
    localparam int TIMER_TIMEOUT = 100;

    logic                clk;
    logic                reset;
    csr_addr_t           csr_raddr;
    csr_data_t           csr_rdata;
    csr_write_t          wr;
    csr_excp_t           excp;
    logic [HW_INT_W-1:0] interrupt;
    logic                has_int;
    logic [1:0]          plv;
    csr_data_t           eentry;
    csr_data_t           era;
    csr_data_t           tid;
    logic [TIMER_W-1:0]  timer;
    logic [TIMER_W-1:0]  cycle_count;

    integer seed = 56745;

    csr_top uut (
        .clk       (clk),
        .reset     (reset),
        .csr_raddr (csr_raddr),
        .csr_rdata (csr_rdata),
        .wr        (wr),
        .excp      (excp),
        .interrupt (interrupt),
        .has_int   (has_int),
        .plv       (plv),
        .eentry    (eentry),
        .era       (era),
        .tid       (tid),
        .timer     (timer)
    );

    task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("Error at time %0t: %s, got %h, expected %h",
                     $time, msg, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out at time %0t while waiting for the %s", $time, what);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped on a timeout");
    endtask

    // inputs change one unit after the edge
    task automatic next_edge();
        @(posedge clk);
        #1;
    endtask

    task automatic clear_strobes();
        wr   = '0;
        excp = '0;
    endtask

    // write plus a same-cycle read of that address
    task automatic write_reg(input csr_addr_t addr, input csr_data_t data);
        wr.en     = 1'b1;
        wr.addr   = addr;
        wr.data   = data;
        csr_raddr = addr;
        #1;
        check(csr_rdata, data, $sformatf("bypass read of csr %h", addr));
        next_edge();
        clear_strobes();
    endtask

    task automatic expect_reg(input csr_addr_t addr, input csr_data_t expected,
                              input string msg);
        csr_raddr = addr;
        #1;
        check(csr_rdata, expected, msg);
        next_edge();
    endtask

    task automatic expect_bit(input csr_addr_t addr, input int pos, input logic value,
                              input string msg);
        csr_raddr = addr;
        #1;
        check(csr_rdata[pos], value, msg);
        next_edge();
    endtask

    task automatic wait_for_int(input int limit, input string what);
        int cycles;
        cycles = 0;
        while (has_int !== 1'b1) begin
            if (cycles == limit) begin
                timeout_fail(what);
            end
            next_edge();
            cycles++;
        end
    endtask

    `include "csr_tests.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // rising edges seen since reset was released
    always @(posedge clk) begin
        if (reset) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    initial begin
        reset     = 1'b1;
        csr_raddr = '0;
        wr        = '0;
        excp      = '0;
        interrupt = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        reset_values();
        write_readback();
        exception_round_trip();
        interrupt_lines();
        oneshot_timer();
        badv_priority();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- loong_csr.f
+incdir+verification
logic/csr_pkg.sv
logic/csr_write_decode.sv
logic/csr_exception_regs.sv
logic/csr_timer.sv
logic/csr_save_bank.sv
logic/csr_read_mux.sv
logic/csr_top.sv
verification/csr_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= csr_tb
LOG       ?= sim.log
FLAGS     ?= --binary --timing -Wno-fatal
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f loong_csr.f
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
